//--- all.f
logic/zx_pkg.sv
logic/zx_ifs.sv
logic/io_decode.sv
logic/ula_port.sv
logic/psg_tone.sv
logic/audio_mixer.sv
logic/zx_audio_io.sv
tests/zx_audio_io_sva.sv
tests/tb_zx_audio_io.sv

//--- tests/tb_zx_audio_io.sv
`timescale 1ns/1ps

module tb_zx_audio_io;
  import zx_pkg::*;

  localparam int CLK_NS = 4;
  localparam int OP_CYC = 5;       // One bus cycle plus margin
  // Cycle budget, reset + ULA + PSG regs + mixer + tone
  localparam int TEST_CYC = 5 + 4 * 4 * OP_CYC + 11 * 3 * OP_CYC
                          + (10 * OP_CYC + 264) + (14 * OP_CYC + 520);
  localparam int WATCHDOG_NS = TEST_CYC * CLK_NS * 3 / 2;

  logic        clk;
  logic        rst_n;
  addr_t       cpu_addr;
  data_t       cpu_dout;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  data_t       cpu_din;
  logic        ear;
  logic [4:0]  kbd_cols;
  logic [4:0]  joy;
  logic [2:0]  border;
  logic        audio_out;
  int          tb_errors = 0;
  logic [31:0] lfsr_state = 32'h2c40_5731;

  zx_audio_io #(
    .PSG_DIV (16)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_addr  (cpu_addr),
    .cpu_dout  (cpu_dout),
    .iorq_n    (iorq_n),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .cpu_din   (cpu_din),
    .ear       (ear),
    .kbd_cols  (kbd_cols),
    .joy       (joy),
    .border    (border),
    .audio_out (audio_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Readback by field width of each AY register
  function automatic data_t psg_expect(input int idx, input data_t d);
    case (idx)
      0, 2, 4, 7:        return d;
      1, 3, 5, 8, 9, 10: return d & 8'h0F;
      default:           return 8'h00;      // Not implemented
    endcase
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else begin
      tb_errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic io_write(input addr_t addr, input data_t data);
    @(posedge clk);
    cpu_addr <= addr;
    cpu_dout <= data;
    iorq_n   <= 1'b0;
    wr_n     <= 1'b0;
    @(posedge clk);
    cpu_dout <= ~data;            // Late bus change, only the first cycle counts
    repeat (2) @(posedge clk);    // Strobes held three cycles
    iorq_n   <= 1'b1;
    wr_n     <= 1'b1;
  endtask

  task automatic io_read(input addr_t addr, output data_t data);
    @(posedge clk);
    cpu_addr <= addr;
    iorq_n   <= 1'b0;
    rd_n     <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);               // Mid-cycle, cpu_din settled
    data = cpu_din;
    @(posedge clk);
    iorq_n   <= 1'b1;
    rd_n     <= 1'b1;
  endtask

  task automatic psg_write(input psg_sel_t idx, input data_t data);
    io_write(16'hFFFD, {4'h0, idx});
    io_write(16'hBFFD, data);
  endtask

  task automatic count_ones(input int cycles, output int ones);
    ones = 0;
    repeat (cycles) begin
      @(negedge clk);
      if (audio_out) ones++;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    data_t d;
    data_t got;
    amp_t  amp_a;
    amp_t  amp_b;
    amp_t  amp_c;
    int    ones;
    int    exp_ones;
    rst_n    <= 1'b0;
    cpu_addr <= 16'hFFFF;
    cpu_dout <= 8'h00;
    iorq_n   <= 1'b1;
    rd_n     <= 1'b1;
    wr_n     <= 1'b1;
    ear      <= 1'b0;              // Keeps the DAC silent until the first write
    kbd_cols <= 5'h1F;
    joy      <= 5'h00;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);     // Quiet stretch

    // ULA port write and readback
    repeat (4) begin
      d = data_t'(take_bits(8));
      io_write(16'h00FE, d);
      @(negedge clk);
      check_value("border", border, d[2:0]);
      @(posedge clk);
      ear      <= 1'(take_bits(1));
      kbd_cols <= 5'(take_bits(5));
      joy      <= 5'(take_bits(5));
      io_read(16'hFEFE, got);
      check_value("cpu_din", got, {1'b1, ear, 1'b1, kbd_cols});
      io_read(16'h001F, got);
      check_value("cpu_din", got, {3'b000, joy});
    end

    // PSG register file through FFFD/BFFD
    for (int idx = 0; idx <= 10; idx++) begin
      d = data_t'(take_bits(8));
      psg_write(psg_sel_t'(idx), d);
      io_read(16'hFFFD, got);
      check_value("cpu_din", got, psg_expect(idx, d));
    end

    // Steady mix, every source on
    amp_a = amp_t'(take_bits(4));
    amp_b = amp_t'(take_bits(4));
    amp_c = amp_t'(take_bits(4));
    psg_write(reg_mixer, 8'h07);   // All tones off
    psg_write(reg_amp_a, {4'h0, amp_a});
    psg_write(reg_amp_b, {4'h0, amp_b});
    psg_write(reg_amp_c, {4'h0, amp_c});
    @(posedge clk);
    ear <= 1'b1;
    io_write(16'h00FE, 8'h18);     // spk and mic set
    repeat (4) @(posedge clk);     // Level register and DAC
    count_ones(256, ones);
    exp_ones = spk_weight + ear_weight + mic_weight + 2 * (amp_a + amp_b + amp_c);
    check_value("audio_out ones", ones, exp_ones);

    // Channel A tone alone, 128 clocks per half-period
    psg_write(4'd0, 8'd8);
    psg_write(4'd1, 8'd0);
    psg_write(reg_mixer, 8'h06);
    psg_write(reg_amp_a, 8'd10);
    psg_write(reg_amp_b, 8'd0);
    psg_write(reg_amp_c, 8'd0);
    @(posedge clk);
    ear <= 1'b0;
    io_write(16'h00FE, 8'h00);
    repeat (4) @(posedge clk);
    count_ones(512, ones);
    assert (ones >= 18 && ones <= 22) else begin
      tb_errors++;
      $display("Error: audio_out ones = 0x%0h, expected 0x14 within 2", ones);
    end

    $display("Checks finished: %0d testbench errors, %0d assertion errors",
             tb_errors, DUT.u_sva.fail_cnt);
    if (tb_errors == 0 && DUT.u_sva.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: stimulus did not finish within %0d ns", WATCHDOG_NS);
    $display("Checks stopped: %0d testbench errors, %0d assertion errors",
             tb_errors, DUT.u_sva.fail_cnt);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- tests/zx_audio_io_sva.sv
`timescale 1ns/1ps

module zx_audio_io_sva (
  input logic           clk,
  input logic           rst_n,
  input logic           iorq_n,
  input logic           rd_n,
  input logic           wr_n,
  input zx_pkg::data_t  cpu_din,
  input logic [2:0]     border,
  input logic           audio_out,
  input logic           spk,
  input logic           mic,
  input logic           ear,
  input zx_pkg::amp_t   ch_a,
  input zx_pkg::amp_t   ch_b,
  input zx_pkg::amp_t   ch_c,
  input zx_pkg::level_t mix_level
);
  import zx_pkg::*;

  int         fail_cnt = 0;   // Read by the testbench at the end
  logic       io_wr;
  logic       wr_seen;
  logic       any_write;      // Some I/O write seen since reset
  logic [2:0] border_q;
  logic [1:0] border_chg;     // Border changes since the last write began, saturating
  level_t     exp_level;
  level_t     exp_level_q;    // Mix one cycle back, as the level register holds it

  assign io_wr = !iorq_n && !wr_n;

  // Mix expected from the source weights, PSG channels count double
  assign exp_level = level_t'(2 * ch_a + 2 * ch_b + 2 * ch_c
                              + (spk ? spk_weight : 8'd0)
                              + (ear ? ear_weight : 8'd0)
                              + (mic ? mic_weight : 8'd0));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_seen     <= 1'b0;
      any_write   <= 1'b0;
      border_q    <= 3'b000;
      border_chg  <= 2'd0;
      exp_level_q <= '0;
    end else begin
      wr_seen     <= io_wr;
      border_q    <= border;
      exp_level_q <= exp_level;
      if (io_wr) begin
        any_write <= 1'b1;
      end
      if (io_wr && !wr_seen) begin
        border_chg <= 2'd0;                      // New bus cycle
      end else if (border != border_q && border_chg != 2'd3) begin
        border_chg <= border_chg + 2'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////

  a_quiet_until_write: assert property (@(posedge clk) !any_write |-> !audio_out)
    else begin
      fail_cnt++;
      $error("audio_out = 0x%0h before any I/O write, expected 0x0",
             $sampled(audio_out));
    end

  a_idle_bus_ff: assert property (@(posedge clk) (iorq_n || rd_n) |-> cpu_din == 8'hFF)
    else begin
      fail_cnt++;
      $error("cpu_din = 0x%0h while no read is active, expected 0xff",
             $sampled(cpu_din));
    end

  a_border_once: assert property (@(posedge clk) disable iff (!rst_n) border_chg <= 2'd1)
    else begin
      fail_cnt++;
      $error("border changed more than once in one write cycle");
    end

  a_mix_level: assert property (@(posedge clk) disable iff (!rst_n)
                                mix_level == exp_level_q)
    else begin
      fail_cnt++;
      $error("mix_level = 0x%0h, expected 0x%0h",
             $sampled(mix_level), $sampled(exp_level_q));
    end

endmodule

bind zx_audio_io zx_audio_io_sva u_sva (
  .clk       (clk),
  .rst_n     (rst_n),
  .iorq_n    (iorq_n),
  .rd_n      (rd_n),
  .wr_n      (wr_n),
  .cpu_din   (cpu_din),
  .border    (border),
  .audio_out (audio_out),
  .spk       (spk),
  .mic       (mic),
  .ear       (ear),
  .ch_a      (ch_a),
  .ch_b      (ch_b),
  .ch_c      (ch_c),
  .mix_level (u_mixer.level)
);

//--- logic/zx_audio_io.sv
`timescale 1ns/1ps

module zx_audio_io #(
  parameter int PSG_DIV = 16
) (
  input  logic          clk,
  input  logic          rst_n,
  // CPU I/O bus
  input  zx_pkg::addr_t cpu_addr,
  input  zx_pkg::data_t cpu_dout,
  input  logic          iorq_n,
  input  logic          rd_n,
  input  logic          wr_n,
  output zx_pkg::data_t cpu_din,
  // Peripherals
  input  logic          ear,
  input  logic [4:0]    kbd_cols,
  input  logic [4:0]    joy,
  output logic [2:0]    border,
  output logic          audio_out
);
  import zx_pkg::*;

  cpu_bus_if bus_if ();
  psg_reg_if psg_if ();

  logic  ula_wr_stb;
  data_t ula_rdata;
  logic  mic;
  logic  spk;
  amp_t  ch_a;
  amp_t  ch_b;
  amp_t  ch_c;

  // Pins onto the internal bus
  assign bus_if.addr   = cpu_addr;
  assign bus_if.wdata  = cpu_dout;
  assign bus_if.iorq_n = iorq_n;
  assign bus_if.rd_n   = rd_n;
  assign bus_if.wr_n   = wr_n;

  //////////////////////////////////////////////////
  // I/O decode
  //////////////////////////////////////////////////

  io_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus_if.dec),
    .psg        (psg_if.host),
    .ula_wr_stb (ula_wr_stb),
    .ula_rdata  (ula_rdata),
    .joy        (joy),
    .cpu_din    (cpu_din)
  );

  //////////////////////////////////////////////////
  // Sound sources and mixer
  //////////////////////////////////////////////////

  ula_port u_ula (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_stb   (ula_wr_stb),
    .wdata    (psg_if.wdata),    // Byte latched by the decoder
    .ear      (ear),
    .kbd_cols (kbd_cols),
    .rdata    (ula_rdata),
    .border   (border),
    .mic      (mic),
    .spk      (spk)
  );

  psg_tone #(
    .PSG_DIV (PSG_DIV)
  ) u_psg (
    .clk  (clk),
    .rst_n(rst_n),
    .regs (psg_if.dev),
    .ch_a (ch_a),
    .ch_b (ch_b),
    .ch_c (ch_c)
  );

  audio_mixer u_mixer (
    .clk       (clk),
    .rst_n     (rst_n),
    .spk       (spk),
    .mic       (mic),
    .ear       (ear),
    .ch_a      (ch_a),
    .ch_b      (ch_b),
    .ch_c      (ch_c),
    .audio_out (audio_out)
  );

endmodule

//--- logic/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         spk,
  input  logic         mic,
  input  logic         ear,
  input  zx_pkg::amp_t ch_a,
  input  zx_pkg::amp_t ch_b,
  input  zx_pkg::amp_t ch_c,
  output logic         audio_out
);
  import zx_pkg::*;

  level_t     src_sum;   // Unregistered mix
  level_t     level;     // Registered mix
  logic [8:0] acc;       // Carry in bit 8

  //////////////////////////////////////////////////
  // Mixer
  //////////////////////////////////////////////////

  always_comb begin
    // PSG channels count double
    src_sum = {3'b000, ch_a, 1'b0} + {3'b000, ch_b, 1'b0} + {3'b000, ch_c, 1'b0};
    if (spk) begin
      src_sum = src_sum + spk_weight;
    end
    if (ear) begin
      src_sum = src_sum + ear_weight;   // Tape input monitored on the speaker
    end
    if (mic) begin
      src_sum = src_sum + mic_weight;
    end
  end

  //////////////////////////////////////////////////
  // First-order sigma-delta DAC
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= '0;
      acc   <= '0;
    end else begin
      level <= src_sum;
      // Old carry is dropped, only the residue is kept
      acc   <= {1'b0, acc[7:0]} + {1'b0, level};
    end
  end

  // Density of ones is level/256
  assign audio_out = acc[8];

endmodule

//--- logic/psg_tone.sv
`timescale 1ns/1ps

module psg_tone #(
  parameter int PSG_DIV = 16         // clk cycles per tone tick
) (
  input  logic         clk,
  input  logic         rst_n,
  psg_reg_if.dev       regs,
  output zx_pkg::amp_t ch_a,
  output zx_pkg::amp_t ch_b,
  output zx_pkg::amp_t ch_c
);
  import zx_pkg::*;

  localparam int DIV_W = (PSG_DIV > 1) ? $clog2(PSG_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(PSG_DIV - 1);

  psg_sel_t         sel;             // Index latched by FFFD
  data_t            per_lo [3];      // R0, R2, R4
  logic [3:0]       per_hi [3];      // R1, R3, R5
  data_t            mixer_en;        // R7, active low tone enables
  amp_t             amp [3];         // R8..R10
  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  period_t          tone_last [3];   // Terminal count per channel
  period_t          tone_cnt [3];
  logic [2:0]       square;
  logic [2:0]       restart;         // Period write on this channel
  amp_t             ch_out [3];

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel      <= '0;
      mixer_en <= '0;                // All tones enabled
      for (int i = 0; i < 3; i++) begin
        per_lo[i] <= '0;
        per_hi[i] <= '0;
        amp[i]    <= '0;
      end
    end else begin
      if (regs.sel_stb) begin
        sel <= regs.wdata[3:0];
      end
      if (regs.data_stb) begin
        case (sel)
          4'd0, 4'd2, 4'd4: per_lo[sel[2:1]] <= regs.wdata;
          4'd1, 4'd3, 4'd5: per_hi[sel[2:1]] <= regs.wdata[3:0];
          reg_mixer:        mixer_en <= regs.wdata;
          reg_amp_a:        amp[0] <= regs.wdata[3:0];
          reg_amp_b:        amp[1] <= regs.wdata[3:0];
          reg_amp_c:        amp[2] <= regs.wdata[3:0];
          default:          ;        // Noise, envelope, I/O not present
        endcase
      end
    end
  end

  // Readback of the selected register
  always_comb begin
    case (sel)
      4'd0, 4'd2, 4'd4: regs.rdata = per_lo[sel[2:1]];
      4'd1, 4'd3, 4'd5: regs.rdata = {4'b0000, per_hi[sel[2:1]]};
      reg_mixer:        regs.rdata = mixer_en;
      reg_amp_a:        regs.rdata = {4'b0000, amp[0]};
      reg_amp_b:        regs.rdata = {4'b0000, amp[1]};
      reg_amp_c:        regs.rdata = {4'b0000, amp[2]};
      default:          regs.rdata = 8'h00;
    endcase
  end

  //////////////////////////////////////////////////
  // Tick divider, replaces the separate AY clock
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign tick = (div_cnt == DIV_LAST);

  //////////////////////////////////////////////////
  // Tone counters
  //////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      // Period 0 behaves as 1
      if ({per_hi[i], per_lo[i]} == 12'd0) begin
        tone_last[i] = '0;
      end else begin
        tone_last[i] = {per_hi[i], per_lo[i]} - 1'b1;
      end
      // Either period byte restarts the channel
      restart[i] = regs.data_stb && (sel[3:1] == 3'(i));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      square <= '0;
      for (int i = 0; i < 3; i++) begin
        tone_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (restart[i]) begin
          tone_cnt[i] <= '0;
        end else if (tick) begin
          if (tone_cnt[i] >= tone_last[i]) begin   // >= covers a shrinking period
            tone_cnt[i] <= '0;
            square[i]   <= ~square[i];
          end else begin
            tone_cnt[i] <= tone_cnt[i] + 1'b1;
          end
        end
      end
    end
  end

  // Disabled tone leaves a steady level
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      ch_out[i] = (mixer_en[i] || square[i]) ? amp[i] : '0;
    end
  end

  assign ch_a = ch_out[0];
  assign ch_b = ch_out[1];
  assign ch_c = ch_out[2];

endmodule

//--- logic/ula_port.sv
`timescale 1ns/1ps

module ula_port (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          wr_stb,
  input  zx_pkg::data_t wdata,
  input  logic          ear,
  input  logic [4:0]    kbd_cols,
  output zx_pkg::data_t rdata,
  output logic [2:0]    border,
  output logic          mic,
  output logic          spk
);

  //////////////////////////////////////////////////
  // Port FE write side
  //////////////////////////////////////////////////

  // Bit layout on OUT (FE)
  //   7..5  unused
  //   4     speaker
  //   3     mic
  //   2..0  border colour
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      border <= 3'b000;   // Black border
      mic    <= 1'b0;
      spk    <= 1'b0;
    end else if (wr_stb) begin
      border <= wdata[2:0];
      mic    <= wdata[3];
      spk    <= wdata[4];
    end
  end

  //////////////////////////////////////////////////
  // Port FE read side
  //////////////////////////////////////////////////

  // Keyboard columns are active low, pressed key reads 0
  // Bit 6 carries the tape input
  assign rdata = {1'b1, ear, 1'b1, kbd_cols};

endmodule

//--- logic/io_decode.sv
`timescale 1ns/1ps

module io_decode (
  input  logic          clk,
  input  logic          rst_n,
  cpu_bus_if.dec        bus,
  psg_reg_if.host       psg,
  output logic          ula_wr_stb,
  input  zx_pkg::data_t ula_rdata,
  input  logic [4:0]    joy,
  output zx_pkg::data_t cpu_din
);

  logic io_wr;        // Write cycle in progress
  logic io_rd;        // Read cycle in progress
  logic wr_seen;      // Write cycle seen on last edge
  logic wr_first;     // First cycle of a write
  logic ay_sel_hit;   // FFFD
  logic ay_dat_hit;   // BFFD
  logic ula_hit;      // Any even port
  logic joy_hit;      // Kempston port 1F

  //////////////////////////////////////////////////
  // Port address decode
  //////////////////////////////////////////////////

  // AY ports only look at A15, A14 and A1..A0, as on the 128K
  assign ay_sel_hit = bus.addr[15] && bus.addr[14] && (bus.addr[1:0] == 2'b01);
  assign ay_dat_hit = bus.addr[15] && !bus.addr[14] && (bus.addr[1:0] == 2'b01);
  assign ula_hit    = !bus.addr[0];                  // ULA answers every even port
  assign joy_hit    = (bus.addr[7:0] == 8'h1F);

  assign io_wr = !bus.iorq_n && !bus.wr_n;
  assign io_rd = !bus.iorq_n && !bus.rd_n;

  // Rising edge of the write condition
  assign wr_first = io_wr && !wr_seen;

  //////////////////////////////////////////////////
  // Write pulses
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_seen      <= 1'b0;
      psg.sel_stb  <= 1'b0;
      psg.data_stb <= 1'b0;
      ula_wr_stb   <= 1'b0;
    end else begin
      wr_seen      <= io_wr;
      // One pulse per bus cycle, however long the strobes last
      psg.sel_stb  <= wr_first && ay_sel_hit;
      psg.data_stb <= wr_first && ay_dat_hit;
      ula_wr_stb   <= wr_first && ula_hit;
    end
  end

  // Write byte captured together with the pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      psg.wdata <= '0;
    end else if (wr_first) begin
      psg.wdata <= bus.wdata;
    end
  end

  //////////////////////////////////////////////////
  // Read data multiplexer
  //////////////////////////////////////////////////

  always_comb begin
    cpu_din = 8'hFF;                     // Floating bus
    if (io_rd) begin
      if (ay_sel_hit) begin
        cpu_din = psg.rdata;             // AY register readback
      end else if (joy_hit) begin
        cpu_din = {3'b000, joy};         // Kempston, active high
      end else if (ula_hit) begin
        cpu_din = ula_rdata;
      end
    end
  end

endmodule

//--- logic/zx_ifs.sv
`timescale 1ns/1ps

//////////////////////////////////////////////////
// CPU I/O bus as seen by the decoder
//////////////////////////////////////////////////

interface cpu_bus_if;
  import zx_pkg::*;

  addr_t addr;     // Full 16-bit port address
  data_t wdata;    // CPU data out
  logic  iorq_n;
  logic  rd_n;
  logic  wr_n;

  // Driven from the top-level pins
  modport ctrl (output addr, wdata, iorq_n, rd_n, wr_n);

  // Decoder side
  modport dec (input addr, wdata, iorq_n, rd_n, wr_n);

endinterface

//////////////////////////////////////////////////
// Register access path into the PSG
//////////////////////////////////////////////////

interface psg_reg_if;
  import zx_pkg::*;

  logic  sel_stb;   // Latch register index
  logic  data_stb;  // Write selected register
  data_t wdata;     // Latched write byte
  data_t rdata;     // Selected register, combinational

  modport host (output sel_stb, data_stb, wdata, input rdata);

  modport dev (input sel_stb, data_stb, wdata, output rdata);

endinterface

//--- logic/zx_pkg.sv
package zx_pkg;

  //////////////////////////////////////////////////
  // CPU bus widths
  //////////////////////////////////////////////////

  typedef logic [15:0] addr_t;     // Z80 address, A15..A0
  typedef logic [7:0]  data_t;     // Z80 data byte

  //////////////////////////////////////////////////
  // PSG and sound levels
  //////////////////////////////////////////////////

  // Tone half-period in ticks, 12 bits as on the AY
  typedef logic [11:0] period_t;

  typedef logic [3:0]  amp_t;      // Fixed channel amplitude
  typedef logic [3:0]  psg_sel_t;  // AY register index

  // Mixed level fed to the DAC
  typedef logic [7:0]  level_t;

  // Weights of the one-bit sources
  // Loudest source is the beeper, tape sounds sit lower
  localparam level_t spk_weight = 8'd96;
  localparam level_t ear_weight = 8'd32;
  localparam level_t mic_weight = 8'd16;

  // Each PSG channel adds twice its amplitude, up to 30 per channel
  // Worst case 96 + 32 + 16 + 90 = 234
  // So the sum never wraps in level_t

  // AY register map used here
  localparam psg_sel_t reg_mixer = 4'd7;   // Tone disable bits 2:0
  localparam psg_sel_t reg_amp_a = 4'd8;
  localparam psg_sel_t reg_amp_b = 4'd9;
  localparam psg_sel_t reg_amp_c = 4'd10;

endpackage
